//--- hw/core_pkg.sv
package core_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;
    localparam int IMM_W      = 12;
    localparam int WEN_W      = 4;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Instruction bits 31..26
    // Any other code is a no-op
    typedef enum logic [5:0] {
        OP_ADD   = 6'h01,
        OP_SUB   = 6'h02,
        OP_AND   = 6'h03,
        OP_OR    = 6'h04,
        OP_XOR   = 6'h05,
        OP_SLT   = 6'h06,
        OP_SLTU  = 6'h07,
        OP_SLL   = 6'h08,
        OP_SRL   = 6'h09,
        OP_SRA   = 6'h0a,
        OP_ADDI  = 6'h10,
        OP_ANDI  = 6'h11,
        OP_ORI   = 6'h12,
        OP_LU12I = 6'h14
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LU12I
    } alu_op_e;

    ////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rj;
        logic                  rj_read;
        logic [REG_ADDR_W-1:0] rk;
        logic                  rk_read;
        logic [XLEN-1:0]       imm;
        logic                  use_imm;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
    } decode_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       operand_a;
        logic [XLEN-1:0]       operand_b;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
    } dispatch_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic [XLEN-1:0]       data;
    } result_t;

    // Register file write and both forwarding buses
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } reg_write_t;

endpackage

//--- hw/regs_file.sv
`timescale 1ns/10ps

module regs_file (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  core_pkg::reg_write_t            write_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
    output logic [core_pkg::XLEN-1:0]       rdata_a_o,
    output logic [core_pkg::XLEN-1:0]       rdata_b_o
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::REG_COUNT];

    // r0 is never written so it reads zero
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_i.en && (write_i.addr != '0)) begin
            regs[write_i.addr] <= write_i.data;
        end
    end

    // Asynchronous read ports
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     instr_valid_i,
    input  logic [core_pkg::XLEN-1:0] instr_i,
    input  logic [core_pkg::XLEN-1:0] pc_i,
    output core_pkg::decode_t        decode_o
);

    core_pkg::opcode_e            opcode;
    logic [core_pkg::IMM_W-1:0]   imm_field;
    logic                         known;
    core_pkg::decode_t            dec_d;

    assign opcode    = core_pkg::opcode_e'(instr_i[31:26]);
    assign imm_field = instr_i[21:10];

    ////////////////////////////////////////
    // Field extraction and opcode mapping
    ////////////////////////////////////////
    always_comb begin
        dec_d         = '0;
        known         = 1'b1;
        dec_d.valid   = instr_valid_i;
        dec_d.pc      = pc_i;
        dec_d.rd      = instr_i[4:0];
        dec_d.rj      = instr_i[9:5];
        dec_d.rk      = instr_i[14:10];
        dec_d.alu_op  = core_pkg::ALU_ADD;
        // Zero extension unless addi says otherwise
        dec_d.imm     = {{(core_pkg::XLEN - core_pkg::IMM_W){1'b0}}, imm_field};
        dec_d.use_imm = 1'b0;

        case (opcode)
            core_pkg::OP_ADD:  dec_d.alu_op = core_pkg::ALU_ADD;
            core_pkg::OP_SUB:  dec_d.alu_op = core_pkg::ALU_SUB;
            core_pkg::OP_AND:  dec_d.alu_op = core_pkg::ALU_AND;
            core_pkg::OP_OR:   dec_d.alu_op = core_pkg::ALU_OR;
            core_pkg::OP_XOR:  dec_d.alu_op = core_pkg::ALU_XOR;
            core_pkg::OP_SLT:  dec_d.alu_op = core_pkg::ALU_SLT;
            core_pkg::OP_SLTU: dec_d.alu_op = core_pkg::ALU_SLTU;
            core_pkg::OP_SLL:  dec_d.alu_op = core_pkg::ALU_SLL;
            core_pkg::OP_SRL:  dec_d.alu_op = core_pkg::ALU_SRL;
            core_pkg::OP_SRA:  dec_d.alu_op = core_pkg::ALU_SRA;
            core_pkg::OP_ADDI: begin
                dec_d.alu_op  = core_pkg::ALU_ADD;
                dec_d.use_imm = 1'b1;
                dec_d.imm     = {{(core_pkg::XLEN - core_pkg::IMM_W){imm_field[11]}},
                                 imm_field};
            end
            core_pkg::OP_ANDI: begin
                dec_d.alu_op  = core_pkg::ALU_AND;
                dec_d.use_imm = 1'b1;
            end
            core_pkg::OP_ORI: begin
                dec_d.alu_op  = core_pkg::ALU_OR;
                dec_d.use_imm = 1'b1;
            end
            core_pkg::OP_LU12I: begin
                dec_d.alu_op  = core_pkg::ALU_LU12I;
                dec_d.use_imm = 1'b1;
            end
            default: known = 1'b0;
        endcase

        // lu12i has no register source
        dec_d.rj_read   = known && (opcode != core_pkg::OP_LU12I);
        dec_d.rk_read   = known && !dec_d.use_imm;
        dec_d.reg_write = known && instr_valid_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            decode_o <= '0;
        end else begin
            decode_o <= dec_d;
        end
    end

    a_dec_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n_i) !$isunknown(decode_o.valid)
    );

endmodule

//--- hw/dispatch_stage.sv
`timescale 1ns/10ps

module dispatch_stage (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  core_pkg::decode_t               decode_i,
    input  core_pkg::reg_write_t            ex_forward_i,
    input  core_pkg::reg_write_t            wb_forward_i,
    output logic [core_pkg::REG_ADDR_W-1:0] raddr_a_o,
    output logic [core_pkg::REG_ADDR_W-1:0] raddr_b_o,
    input  logic [core_pkg::XLEN-1:0]       rdata_a_i,
    input  logic [core_pkg::XLEN-1:0]       rdata_b_i,
    output core_pkg::dispatch_t             dispatch_o
);

    core_pkg::dispatch_t       disp_q;
    logic                      late_a_q;
    logic                      late_b_q;
    logic                      hit_a;
    logic                      hit_b;
    logic [core_pkg::XLEN-1:0] src_a;
    logic [core_pkg::XLEN-1:0] src_b;

    // Newest copy of a source from execute, writeback or register file
    function automatic logic [core_pkg::XLEN-1:0] pick_src(
        input logic [core_pkg::REG_ADDR_W-1:0] addr,
        input logic [core_pkg::XLEN-1:0]       rf_data,
        input core_pkg::reg_write_t            ex_fwd,
        input core_pkg::reg_write_t            wb_fwd
    );
        if (addr == '0) begin
            return '0;
        end else if (ex_fwd.en && (ex_fwd.addr == addr)) begin
            return ex_fwd.data;
        end else if (wb_fwd.en && (wb_fwd.addr == addr)) begin
            return wb_fwd.data;
        end
        return rf_data;
    endfunction

    assign raddr_a_o = decode_i.rj;
    assign raddr_b_o = decode_i.rk;

    assign src_a = decode_i.rj_read ?
                   pick_src(decode_i.rj, rdata_a_i, ex_forward_i, wb_forward_i) : '0;
    assign src_b = decode_i.use_imm ? decode_i.imm :
                   decode_i.rk_read ?
                   pick_src(decode_i.rk, rdata_b_i, ex_forward_i, wb_forward_i) : '0;

    // Producer one slot ahead lands in execute next cycle
    assign hit_a = disp_q.valid && disp_q.reg_write && decode_i.rj_read &&
                   (decode_i.rj != '0) && (decode_i.rj == disp_q.rd);
    assign hit_b = disp_q.valid && disp_q.reg_write && decode_i.rk_read &&
                   !decode_i.use_imm && (decode_i.rk != '0) && (decode_i.rk == disp_q.rd);

    ////////////////////////////////////////
    // Dispatch register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            disp_q   <= '0;
            late_a_q <= 1'b0;
            late_b_q <= 1'b0;
        end else begin
            disp_q.valid     <= decode_i.valid;
            disp_q.pc        <= decode_i.pc;
            disp_q.alu_op    <= decode_i.alu_op;
            disp_q.operand_a <= src_a;
            disp_q.operand_b <= src_b;
            disp_q.rd        <= decode_i.rd;
            disp_q.reg_write <= decode_i.reg_write;
            late_a_q         <= hit_a;
            late_b_q         <= hit_b;
        end
    end

    // Back-to-back dependency picks up the execute result register here
    always_comb begin
        dispatch_o = disp_q;
        if (late_a_q) begin
            dispatch_o.operand_a = ex_forward_i.data;
        end
        if (late_b_q) begin
            dispatch_o.operand_b = ex_forward_i.data;
        end
    end

endmodule

//--- hw/exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  core_pkg::dispatch_t  dispatch_i,
    output core_pkg::result_t    result_o,
    output core_pkg::reg_write_t ex_forward_o
);

    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [4:0]                shamt;
    logic [core_pkg::XLEN-1:0] alu_res;

    assign op_a  = dispatch_i.operand_a;
    assign op_b  = dispatch_i.operand_b;
    // Low five bits of B for a 32-bit shift
    assign shamt = op_b[4:0];

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb begin
        alu_res = '0;
        case (dispatch_i.alu_op)
            core_pkg::ALU_ADD:  alu_res = op_a + op_b;
            core_pkg::ALU_SUB:  alu_res = op_a - op_b;
            core_pkg::ALU_AND:  alu_res = op_a & op_b;
            core_pkg::ALU_OR:   alu_res = op_a | op_b;
            core_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            core_pkg::ALU_SLT:  alu_res[0] = $signed(op_a) < $signed(op_b);
            core_pkg::ALU_SLTU: alu_res[0] = op_a < op_b;
            core_pkg::ALU_SLL:  alu_res = op_a << shamt;
            core_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            core_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            core_pkg::ALU_LU12I: begin
                alu_res = {op_b[core_pkg::IMM_W-1:0],
                           {(core_pkg::XLEN - core_pkg::IMM_W){1'b0}}};
            end
            default: alu_res = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else begin
            result_o.valid     <= dispatch_i.valid;
            result_o.pc        <= dispatch_i.pc;
            result_o.rd        <= dispatch_i.rd;
            result_o.reg_write <= dispatch_i.reg_write;
            result_o.data      <= alu_res;
        end
    end

    // Forward straight from the result register
    assign ex_forward_o.en   = result_o.valid && result_o.reg_write;
    assign ex_forward_o.addr = result_o.rd;
    assign ex_forward_o.data = result_o.data;

    a_ex_valid_follows_input: assert property (
        @(posedge clk) disable iff (!arst_n_i) result_o.valid |-> $past(dispatch_i.valid)
    );

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/10ps

module wb_stage (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  core_pkg::result_t               result_i,
    output core_pkg::reg_write_t            rf_write_o,
    output core_pkg::reg_write_t            wb_forward_o,
    output logic [core_pkg::XLEN-1:0]       debug_wb_pc_o,
    output logic [core_pkg::WEN_W-1:0]      debug_wb_rf_wen_o,
    output logic [core_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [core_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);

    core_pkg::reg_write_t      commit_q;
    logic [core_pkg::XLEN-1:0] pc_q;

    ////////////////////////////////////////
    // Commit register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_q <= '0;
            pc_q     <= '0;
        end else begin
            // Writes to r0 are dropped here
            commit_q.en   <= result_i.valid && result_i.reg_write && (result_i.rd != '0);
            commit_q.addr <= result_i.rd;
            commit_q.data <= result_i.data;
            pc_q          <= result_i.pc;
        end
    end

    assign rf_write_o   = commit_q;
    assign wb_forward_o = commit_q;

    // Single commit lane drives only bit 0 of the mask
    assign debug_wb_pc_o       = pc_q;
    assign debug_wb_rf_wen_o   = {{(core_pkg::WEN_W - 1){1'b0}}, commit_q.en};
    assign debug_wb_rf_wnum_o  = commit_q.addr;
    assign debug_wb_rf_wdata_o = commit_q.data;

    a_wb_wen_mask: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (debug_wb_rf_wen_o[core_pkg::WEN_W-1:1] == '0) &&
        (debug_wb_rf_wen_o[0] -> (debug_wb_rf_wnum_o != '0))
    );

endmodule

//--- hw/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            instr_valid_i,
    input  logic [core_pkg::XLEN-1:0]       instr_i,
    input  logic [core_pkg::XLEN-1:0]       pc_i,
    output logic [core_pkg::XLEN-1:0]       debug_wb_pc_o,
    output logic [core_pkg::WEN_W-1:0]      debug_wb_rf_wen_o,
    output logic [core_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [core_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);

    // Stage to stage
    core_pkg::decode_t   dec_disp;
    core_pkg::dispatch_t disp_ex;
    core_pkg::result_t   ex_wb;

    // Register file and forwarding
    core_pkg::reg_write_t            rf_write;
    core_pkg::reg_write_t            ex_forward;
    core_pkg::reg_write_t            wb_forward;
    logic [core_pkg::REG_ADDR_W-1:0] raddr_a;
    logic [core_pkg::REG_ADDR_W-1:0] raddr_b;
    logic [core_pkg::XLEN-1:0]       rdata_a;
    logic [core_pkg::XLEN-1:0]       rdata_b;

    decode_stage u_decode (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .decode_o     (dec_disp)
    );

    dispatch_stage u_dispatch (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .decode_i    (dec_disp),
        .ex_forward_i(ex_forward),
        .wb_forward_i(wb_forward),
        .raddr_a_o   (raddr_a),
        .raddr_b_o   (raddr_b),
        .rdata_a_i   (rdata_a),
        .rdata_b_i   (rdata_b),
        .dispatch_o  (disp_ex)
    );

    exec_stage u_exec (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .dispatch_i  (disp_ex),
        .result_o    (ex_wb),
        .ex_forward_o(ex_forward)
    );

    wb_stage u_wb (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .result_i           (ex_wb),
        .rf_write_o         (rf_write),
        .wb_forward_o       (wb_forward),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    regs_file u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .write_i  (rf_write),
        .raddr_a_i(raddr_a),
        .raddr_b_i(raddr_b),
        .rdata_a_o(rdata_a),
        .rdata_b_o(rdata_b)
    );

endmodule

//--- bench/tb_cpu_top.sv
`timescale 1ns/10ps

module tb_cpu_top;

    // Cycle budget of each test, summed for the watchdog
    localparam int RESET_CYCLES    = 8;
    localparam int TEST_CYCLES     = (RESET_CYCLES + 10) + 40 + 40 + 20 + 20 + (2 * 200 + 8);
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;
    localparam int LATENCY_SLOTS   = 4;

    typedef struct packed {
        logic [core_pkg::WEN_W-1:0]      wen;
        logic [core_pkg::XLEN-1:0]       pc;
        logic [core_pkg::REG_ADDR_W-1:0] wnum;
        logic [core_pkg::XLEN-1:0]       wdata;
    } commit_t;

    logic                            clk;
    logic                            arst_n_i;
    logic                            instr_valid_i;
    logic [core_pkg::XLEN-1:0]       instr_i;
    logic [core_pkg::XLEN-1:0]       pc_i;
    logic [core_pkg::XLEN-1:0]       debug_wb_pc_o;
    logic [core_pkg::WEN_W-1:0]      debug_wb_rf_wen_o;
    logic [core_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o;
    logic [core_pkg::XLEN-1:0]       debug_wb_rf_wdata_o;

    logic [core_pkg::XLEN-1:0] model_regs [core_pkg::REG_COUNT];
    logic [core_pkg::XLEN-1:0] next_pc;
    logic [31:0]               lfsr_state = 32'h2b42ea17;
    commit_t                   exp_q [$];
    string                     cur_test;
    int                        checks;
    int                        errors;

    cpu_top dut (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .instr_valid_i      (instr_valid_i),
        .instr_i            (instr_i),
        .pc_i               (pc_i),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_reg(input logic [5:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [4:0] rk);
        return {op, 11'b0, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [5:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [11:0] imm);
        return {op, 4'b0, imm, rj, rd};
    endfunction

    // Architectural result of one instruction and its write flag
    function automatic logic model_exec(input logic [31:0] instr, output logic [31:0] res);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic        wr;
        a    = model_regs[instr[9:5]];
        b    = model_regs[instr[14:10]];
        simm = {{20{instr[21]}}, instr[21:10]};
        zimm = {20'b0, instr[21:10]};
        wr   = 1'b1;
        res  = '0;
        case (instr[31:26])
            core_pkg::OP_ADD:   res = a + b;
            core_pkg::OP_SUB:   res = a - b;
            core_pkg::OP_AND:   res = a & b;
            core_pkg::OP_OR:    res = a | b;
            core_pkg::OP_XOR:   res = a ^ b;
            core_pkg::OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_pkg::OP_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
            core_pkg::OP_SLL:   res = a << b[4:0];
            core_pkg::OP_SRL:   res = a >> b[4:0];
            core_pkg::OP_SRA:   res = $signed(a) >>> b[4:0];
            core_pkg::OP_ADDI:  res = a + simm;
            core_pkg::OP_ANDI:  res = a & zimm;
            core_pkg::OP_ORI:   res = a | zimm;
            core_pkg::OP_LU12I: res = {instr[21:10], 20'b0};
            default:            wr = 1'b0;
        endcase
        return wr;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic compare_commit(input commit_t e);
        check_value("wen", e.wen, debug_wb_rf_wen_o);
        if (e.wen != '0) begin
            check_value("pc", e.pc, debug_wb_pc_o);
            check_value("wnum", e.wnum, debug_wb_rf_wnum_o);
            check_value("wdata", e.wdata, debug_wb_rf_wdata_o);
        end
    endtask

    // Check the commit due now and drive the next input
    task automatic step(input logic valid, input logic [31:0] instr);
        commit_t     e;
        logic [31:0] res;
        @(negedge clk);
        if (exp_q.size() == LATENCY_SLOTS) begin
            compare_commit(exp_q.pop_front());
        end
        instr_valid_i = valid;
        instr_i       = instr;
        pc_i          = next_pc;
        e             = '0;
        if (valid && model_exec(instr, res) && (instr[4:0] != 5'd0)) begin
            model_regs[instr[4:0]] = res;
            e.wen   = 4'b0001;
            e.pc    = next_pc;
            e.wnum  = instr[4:0];
            e.wdata = res;
        end
        exp_q.push_back(e);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic issue_reg(input logic [5:0] op, input int rd, input int rj, input int rk);
        step(1'b1, enc_reg(op, rd[4:0], rj[4:0], rk[4:0]));
    endtask

    task automatic issue_imm(input logic [5:0] op, input int rd, input int rj,
                             input logic [11:0] imm);
        step(1'b1, enc_imm(op, rd[4:0], rj[4:0], imm));
    endtask

    task automatic drain();
        repeat (LATENCY_SLOTS) step(1'b0, '0);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic reset_state();
        commit_t idle;
        idle     = '0;
        cur_test = "reset_state";
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("wen in reset", '0, debug_wb_rf_wen_o);
        end
        arst_n_i = 1'b1;
        // Empty slots sampled during reset
        repeat (LATENCY_SLOTS) exp_q.push_back(idle);
        // Valid low with a live-looking instruction on the bus
        repeat (6) step(1'b0, enc_imm(core_pkg::OP_ADDI, 5'd1, 5'd0, 12'h7ff));
        drain();
    endtask

    task automatic all_opcodes();
        cur_test = "all_opcodes";
        issue_imm(core_pkg::OP_ADDI, 1, 0, 12'h7ff);
        issue_imm(core_pkg::OP_LU12I, 2, 0, 12'h800);
        issue_imm(core_pkg::OP_ADDI, 3, 0, 12'hffb);
        issue_imm(core_pkg::OP_LU12I, 4, 0, 12'h123);
        issue_imm(core_pkg::OP_ADDI, 5, 0, 12'h003);
        drain();
        issue_imm(core_pkg::OP_ORI, 4, 4, 12'h456);
        issue_reg(core_pkg::OP_ADD, 10, 1, 3);
        issue_reg(core_pkg::OP_SUB, 11, 1, 2);
        issue_reg(core_pkg::OP_AND, 12, 3, 1);
        issue_reg(core_pkg::OP_OR, 13, 2, 5);
        issue_reg(core_pkg::OP_XOR, 14, 3, 2);
        issue_reg(core_pkg::OP_SLT, 15, 3, 1);
        issue_reg(core_pkg::OP_SLTU, 16, 3, 1);
        issue_reg(core_pkg::OP_SLL, 17, 4, 5);
        issue_reg(core_pkg::OP_SRL, 18, 2, 5);
        issue_reg(core_pkg::OP_SRA, 19, 2, 5);
        issue_imm(core_pkg::OP_ADDI, 20, 3, 12'hfff);
        issue_imm(core_pkg::OP_ANDI, 21, 3, 12'hf0f);
        issue_imm(core_pkg::OP_ORI, 22, 2, 12'h0ff);
        issue_imm(core_pkg::OP_LU12I, 23, 0, 12'habc);
        drain();
    endtask

    task automatic forwarding_chain();
        cur_test = "forwarding_chain";
        issue_imm(core_pkg::OP_ADDI, 6, 0, 12'h011);
        issue_imm(core_pkg::OP_ADDI, 7, 6, 12'h001);
        issue_reg(core_pkg::OP_XOR, 8, 7, 6);
        issue_reg(core_pkg::OP_ADD, 9, 8, 6);
        issue_reg(core_pkg::OP_SUB, 10, 7, 9);
        issue_reg(core_pkg::OP_SLL, 11, 10, 8);
        issue_imm(core_pkg::OP_ORI, 12, 8, 12'h0f0);
        // Dense chain on both operands
        for (int i = 0; i < 8; i++) begin
            issue_reg(core_pkg::OP_ADD, 13, 13, 7);
            issue_reg(core_pkg::OP_XOR, 7, 6, 13);
        end
        drain();
    endtask

    task automatic zero_register();
        cur_test = "zero_register";
        issue_imm(core_pkg::OP_ADDI, 0, 1, 12'h005);
        issue_reg(core_pkg::OP_ADD, 24, 0, 0);
        issue_imm(core_pkg::OP_ORI, 0, 2, 12'h0ff);
        issue_reg(core_pkg::OP_OR, 25, 0, 24);
        issue_imm(core_pkg::OP_ADDI, 30, 0, 12'h000);
        drain();
    endtask

    task automatic bubbles_unknown();
        cur_test = "bubbles_unknown";
        issue_imm(core_pkg::OP_ADDI, 26, 0, 12'h123);
        step(1'b0, enc_imm(core_pkg::OP_ADDI, 5'd26, 5'd0, 12'hfff));
        issue_reg(core_pkg::OP_ADD, 27, 26, 26);
        step(1'b1, enc_reg(6'h3f, 5'd27, 5'd26, 5'd26));
        issue_reg(core_pkg::OP_ADD, 28, 27, 0);
        step(1'b1, enc_imm(6'h00, 5'd28, 5'd0, 12'hfff));
        step(1'b0, '0);
        step(1'b0, '0);
        issue_reg(core_pkg::OP_SUB, 29, 28, 26);
        drain();
    endtask

    function automatic logic [5:0] pick_opcode(input logic [3:0] idx);
        case (idx)
            4'd0:    return core_pkg::OP_ADD;
            4'd1:    return core_pkg::OP_SUB;
            4'd2:    return core_pkg::OP_AND;
            4'd3:    return core_pkg::OP_OR;
            4'd4:    return core_pkg::OP_XOR;
            4'd5:    return core_pkg::OP_SLT;
            4'd6:    return core_pkg::OP_SLTU;
            4'd7:    return core_pkg::OP_SLL;
            4'd8:    return core_pkg::OP_SRL;
            4'd9:    return core_pkg::OP_SRA;
            4'd10:   return core_pkg::OP_ADDI;
            4'd11:   return core_pkg::OP_ANDI;
            4'd12:   return core_pkg::OP_ORI;
            4'd13:   return core_pkg::OP_LU12I;
            4'd14:   return 6'h3f;
            default: return 6'h00;
        endcase
    endfunction

    task automatic random_stream();
        logic [31:0] r;
        logic [5:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [11:0] tail;
        cur_test = "random_stream";
        for (int i = 0; i < 200; i++) begin
            if (rand_bits(2) == 0) begin
                step(1'b0, rand_bits(32));
            end
            r    = rand_bits(4);
            op   = pick_opcode(r[3:0]);
            // Few registers so dependencies are common
            r    = rand_bits(3);
            rd   = r[4:0];
            r    = rand_bits(3);
            rj   = r[4:0];
            if (op >= 6'h10 && op <= 6'h14) begin
                r = rand_bits(12);
            end else begin
                r = rand_bits(3);
            end
            tail = r[11:0];
            step(1'b1, enc_imm(op, rd, rj, tail));
        end
        drain();
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////
    initial begin
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        next_pc       = 32'h1c00_0000;
        checks        = 0;
        errors        = 0;
        for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        reset_state();
        all_opcodes();
        forwarding_chain();
        zero_register();
        bubbles_unknown();
        random_stream();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- build.f
hw/core_pkg.sv
hw/regs_file.sv
hw/decode_stage.sv
hw/dispatch_stage.sv
hw/exec_stage.sv
hw/wb_stage.sv
hw/cpu_top.sv
bench/tb_cpu_top.sv
